/* sources.f */
rtl/ltc2195_pkg.sv
rtl/spi_master.sv
rtl/adc_config_seq.sv
rtl/lane_deserializer.sv
rtl/frame_aligner.sv
rtl/sample_assembler.sv
rtl/ltc2195_ctrl.sv
dv/ltc2195_assertions.sv
dv/tb_ltc2195.sv

/* run.sh */
#!/bin/sh
# Compile and run the ltc2195_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_ltc2195 -f sources.f -o sim_tb_ltc2195

# The simulation exits non-zero on failure, the output decides
out=$(./obj_dir/sim_tb_ltc2195 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^ALL TESTS PASSED$"; then
	exit 0
fi
exit 1

/* dv/tb_ltc2195.sv */
// Testbench for ltc2195_ctrl: clock, reset, SPI monitor, lane model, sample checks and timeout
module tb_ltc2195;
	import ltc2195_pkg::*;

	localparam int SPI_CLK_DIV    = 4;
	localparam int N_CMDS         = 20;  // Random page 31h writes
	localparam int N_OTHER        = 10;  // Commands on other pages
	localparam int N_SAMPLES      = 200; // Samples to check after lock
	// POR wait, 3 init + 20 host frames, then slack for the capture checks
	localparam int TIMEOUT_CYCLES = int'(POR_WAIT_CYCLES) + 23 * (32 * SPI_CLK_DIV + 8) + 2000;

	logic               clk_in = 1'b0;
	logic               rst_in;
	logic               cmd_trig;
	logic [15:0]        cmd_addr;
	logic [15:0]        cmd_data;
	logic               cfg_ready;
	logic               spi_scs;
	logic               spi_sck;
	logic               spi_sdo;
	logic [N_LANES-1:0] lane_d;
	sample_t            adc0;
	sample_t            adc1;
	lane_word_t         frame;
	logic               sample_valid;
	logic               frame_locked;

	int          cyc;             // Rising edges since start
	logic [15:0] spi_frames[$];   // Frames seen on the SPI pins
	int          exp_cyc[$];      // Edge on which each word's sample_valid is due
	sample_t     exp_a0[$];
	sample_t     exp_a1[$];
	int          samples_checked;
	logic        lock_seen;       // frame_locked has been high once

	ltc2195_ctrl #(
		.SPI_CLK_DIV (SPI_CLK_DIV)
	) u_ltc2195_ctrl (
		.clk_in       (clk_in),
		.rst_in       (rst_in),
		.cmd_trig     (cmd_trig),
		.cmd_addr     (cmd_addr),
		.cmd_data     (cmd_data),
		.cfg_ready    (cfg_ready),
		.spi_scs      (spi_scs),
		.spi_sck      (spi_sck),
		.spi_sdo      (spi_sdo),
		.lane_d       (lane_d),
		.adc0         (adc0),
		.adc1         (adc1),
		.frame        (frame),
		.sample_valid (sample_valid),
		.frame_locked (frame_locked)
	);

	initial begin
		forever #20 clk_in = ~clk_in; // Period 40
	end

	////////////////////////////////////////
	// Helpers
	task automatic stop_on_failure();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at the first failed check");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error: time %0t signal %s got %0h expected %0h", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic wait_cfg_ready();
		@(negedge clk_in);
		while (!cfg_ready)
			@(negedge clk_in); // Sequencer still busy
	endtask

	// One-cycle command pulse, seen by the DUT on the second edge
	task automatic pulse_command(input logic [15:0] addr, input logic [15:0] data);
		@(posedge clk_in);
		cmd_trig <= 1'b1;
		cmd_addr <= addr;
		cmd_data <= data;
		@(posedge clk_in);
		cmd_trig <= 1'b0;
	endtask

	////////////////////////////////////////
	// Host side sequence
	initial begin : main_sequence
		logic [15:0] addr;
		logic [15:0] data;
		logic [7:0]  page;
		int          frames_rd;
		void'($urandom(32'h9168));
		rst_in    <= 1'b1;
		cmd_trig  <= 1'b0;
		cmd_addr  <= '0;
		cmd_data  <= '0;
		frames_rd = 0;

		@(negedge clk_in); // Inside reset, all control outputs idle
		check_value("spi_scs", 32'(spi_scs), 32'd1);
		check_value("spi_sck", 32'(spi_sck), 32'd0);
		check_value("cfg_ready", 32'(cfg_ready), 32'd0);
		check_value("sample_valid", 32'(sample_valid), 32'd0);
		check_value("frame_locked", 32'(frame_locked), 32'd0);
		repeat (2) @(posedge clk_in);
		rst_in <= 1'b0; // Released after 3 edges
		@(negedge clk_in);
		check_value("cfg_ready", 32'(cfg_ready), 32'd0); // POR wait running

		// Power-on init frames, all three before cfg_ready
		wait_cfg_ready();
		check_value("init frame count", 32'(spi_frames.size()), 32'd3);
		check_value("init frame 0", 32'(spi_frames[0]), 32'(INIT_WORD_RESET));
		check_value("init frame 1", 32'(spi_frames[1]), 32'(INIT_WORD_FORMAT));
		check_value("init frame 2", 32'(spi_frames[2]), 32'(INIT_WORD_LANES));
		frames_rd = 3;

		// Host SPI writes, each followed by a decoy while busy
		for (int i = 0; i < N_CMDS; i++) begin
			addr = {8'(CMD_PAGE_SPI_WRITE), 8'($urandom)};
			data = 16'($urandom);
			pulse_command(addr, data);
			@(negedge clk_in);
			check_value("cfg_ready", 32'(cfg_ready), 32'd0); // Fell after accept
			pulse_command({8'(CMD_PAGE_SPI_WRITE), 8'($urandom)}, 16'($urandom));
			wait_cfg_ready();
			check_value("spi frame count", 32'(spi_frames.size() - frames_rd), 32'd1);
			// Write bit 0, 7-bit register address, data byte
			check_value("spi frame", 32'(spi_frames[frames_rd]),
				((32'(addr) & 32'h7F) << 8) | (32'(data) & 32'hFF));
			frames_rd++;
		end

		// Other pages, 32h first, must leave the SPI bus alone
		for (int i = 0; i < N_OTHER; i++) begin
			page = (i == 0) ? 8'h32 : 8'($urandom);
			if (page == 8'(CMD_PAGE_SPI_WRITE))
				page = 8'h30;
			pulse_command({page, 8'($urandom)}, 16'($urandom));
			repeat (8) begin
				@(negedge clk_in);
				check_value("cfg_ready", 32'(cfg_ready), 32'd1);
				check_value("spi_scs", 32'(spi_scs), 32'd1);
			end
		end

		// Capture path checked by the pin monitor
		while (!(lock_seen && samples_checked >= N_SAMPLES))
			@(negedge clk_in);
		$display("ALL TESTS PASSED");
		$finish;
	end

	////////////////////////////////////////
	// Lane model and timeout
	initial begin : lane_model
		int                 junk_left; // Leading junk bits, sets the offset
		int                 bit_idx;   // Position in the word, first bit is 0
		sample_t            word_a0;
		sample_t            word_a1;
		logic [N_LANES-1:0] bits;
		lane_d  <= '0;
		cyc     = 0;
		bit_idx = 0;
		word_a0 = '0;
		word_a1 = '0;
		@(posedge clk_in);
		junk_left = int'($urandom_range(7, 0));
		forever begin
			cyc = cyc + 1;
			if (cyc >= TIMEOUT_CYCLES) begin
				$display("timeout after %0d cycles before all checks were done", cyc);
				stop_on_failure();
			end
			if (junk_left > 0) begin
				lane_d    <= N_LANES'($urandom);
				junk_left = junk_left - 1;
			end else begin
				if (bit_idx == 0) begin
					word_a0 = 16'($urandom);
					word_a1 = 16'($urandom);
				end
				// Inverse interleave, MSB pair first
				bits[0] = word_a0[15 - 2*bit_idx];
				bits[1] = word_a0[14 - 2*bit_idx];
				bits[2] = word_a1[15 - 2*bit_idx];
				bits[3] = word_a1[14 - 2*bit_idx];
				bits[4] = TRAINING_PATTERN[7 - bit_idx]; // Frame lane
				lane_d  <= bits;
				if (bit_idx == 7) begin
					exp_cyc.push_back(cyc + 3); // sample_valid three edges on
					exp_a0.push_back(word_a0);
					exp_a1.push_back(word_a1);
				end
				bit_idx = (bit_idx + 1) % 8;
			end
			@(posedge clk_in);
		end
	end

	////////////////////////////////////////
	// SPI and sample monitor, sampled on falling clk_in
	initial begin : pin_monitor
		logic        sck_prev;
		logic [15:0] spi_shift;
		int          spi_bits;
		int          exp_rd;
		sck_prev        = 1'b0;
		spi_shift       = '0;
		spi_bits        = 0;
		exp_rd          = 0;
		lock_seen       = 1'b0;
		samples_checked = 0;
		forever begin
			@(negedge clk_in);
			if (spi_scs === 1'b0 && spi_sck === 1'b1 && !sck_prev) begin
				spi_shift = {spi_shift[14:0], spi_sdo}; // MSB first
				spi_bits++;
				if (spi_bits == 16) begin
					spi_frames.push_back(spi_shift);
					spi_bits = 0;
				end
			end
			if (spi_scs === 1'b1 && spi_bits != 0) begin
				$display("chip select released after %0d of 16 SCK periods", spi_bits);
				stop_on_failure();
			end
			sck_prev = (spi_sck === 1'b1);

			if (frame_locked === 1'b1)
				lock_seen = 1'b1;
			if (lock_seen) begin
				check_value("frame_locked", 32'(frame_locked), 32'd1); // No loss of lock
				if (sample_valid === 1'b1) begin
					while (samples_checked == 0 && exp_rd < exp_cyc.size()
						&& exp_cyc[exp_rd] < cyc)
						exp_rd++; // Words from before the lock
					if (exp_rd >= exp_cyc.size() || exp_cyc[exp_rd] != cyc) begin
						$display("sample_valid at cycle %0d matches no word sent", cyc);
						stop_on_failure();
					end
					check_value("frame", 32'(frame), 32'(TRAINING_PATTERN));
					check_value("adc0", 32'(adc0), 32'(exp_a0[exp_rd]));
					check_value("adc1", 32'(adc1), 32'(exp_a1[exp_rd]));
					exp_rd++;
					samples_checked++;
				end
			end
		end
	end

endmodule

/* dv/ltc2195_assertions.sv */
// Concurrent SPI pin and sample_valid assertions, bound into spi_master and sample_assembler
module ltc2195_assertions (
	input logic clk_in,
	input logic rst_in,
	input logic spi_scs,
	input logic spi_sck,
	input logic spi_ready,
	input logic spi_start,
	input logic sample_valid
);

	// SCK idles low outside a frame
	a_sck_idle: assert property (@(posedge clk_in) disable iff (rst_in) spi_scs |-> !spi_sck)
		else $error("spi_sck high while spi_scs is high");

	// Start while idle opens a frame, master busy from the next edge
	a_ready_busy: assert property (@(posedge clk_in) disable iff (rst_in)
		(spi_start && spi_ready) |=> (!spi_scs && !spi_ready))
		else $error("spi_start accepted without spi_scs low and spi_ready low");

	a_valid_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
		sample_valid |=> !sample_valid)
		else $error("sample_valid high on two edges in a row");

endmodule

bind spi_master ltc2195_assertions u_spi_checks (
	.clk_in       (clk_in),
	.rst_in       (rst_in),
	.spi_scs      (spi_scs),
	.spi_sck      (spi_sck),
	.spi_ready    (spi_ready),
	.spi_start    (spi_start),
	.sample_valid (1'b0) // No samples here
);

bind sample_assembler ltc2195_assertions u_sample_checks (
	.clk_in       (clk_in),
	.rst_in       (rst_in),
	.spi_scs      (1'b1), // Bus idle view
	.spi_sck      (1'b0),
	.spi_ready    (1'b1),
	.spi_start    (1'b0),
	.sample_valid (sample_valid)
);

/* rtl/ltc2195_ctrl.sv */
// Top level joining the ADC configuration path and the lane capture path
module ltc2195_ctrl #(
	parameter int SPI_CLK_DIV = 4 // clk_in cycles per SCK half-period
) (
	input  logic                            clk_in,
	input  logic                            rst_in,
	input  logic                            cmd_trig,
	input  logic [15:0]                     cmd_addr,
	input  logic [15:0]                     cmd_data,
	output logic                            cfg_ready,
	output logic                            spi_scs,
	output logic                            spi_sck,
	output logic                            spi_sdo,
	input  logic [ltc2195_pkg::N_LANES-1:0] lane_d,
	output ltc2195_pkg::sample_t            adc0,
	output ltc2195_pkg::sample_t            adc1,
	output ltc2195_pkg::lane_word_t         frame,
	output logic                            sample_valid,
	output logic                            frame_locked
);
	import ltc2195_pkg::*;

	////////////////////////////////////////
	// Configuration path
	spi_word_t spi_word;
	logic      spi_start;
	logic      spi_ready;

	adc_config_seq u_adc_config_seq (
		.clk_in    (clk_in),
		.rst_in    (rst_in),
		.cmd_trig  (cmd_trig),
		.cmd_addr  (cmd_addr),
		.cmd_data  (cmd_data),
		.spi_ready (spi_ready),
		.spi_word  (spi_word),
		.spi_start (spi_start),
		.cfg_ready (cfg_ready)
	);

	spi_master #(
		.SPI_CLK_DIV (SPI_CLK_DIV)
	) u_spi_master (
		.clk_in    (clk_in),
		.rst_in    (rst_in),
		.spi_word  (spi_word),
		.spi_start (spi_start),
		.spi_ready (spi_ready),
		.spi_scs   (spi_scs),
		.spi_sck   (spi_sck),
		.spi_sdo   (spi_sdo)
	);

	////////////////////////////////////////
	// Capture path
	lane_word_t [N_LANES-1:0] words;
	logic                     word_valid;
	logic                     slip;

	lane_deserializer u_lane_deserializer (
		.clk_in     (clk_in),
		.rst_in     (rst_in),
		.lane_d     (lane_d),
		.slip       (slip),
		.words      (words),
		.word_valid (word_valid)
	);

	frame_aligner u_frame_aligner (
		.clk_in       (clk_in),
		.rst_in       (rst_in),
		.frame_word   (words[N_LANES-1]), // Frame lane
		.word_valid   (word_valid),
		.slip         (slip),
		.frame_locked (frame_locked)
	);

	sample_assembler u_sample_assembler (
		.clk_in       (clk_in),
		.rst_in       (rst_in),
		.words        (words),
		.word_valid   (word_valid),
		.adc0         (adc0),
		.adc1         (adc1),
		.frame        (frame),
		.sample_valid (sample_valid)
	);

endmodule

/* rtl/sample_assembler.sv */
// Rebuilds the two ADC samples from interleaved lane words and registers the frame word
module sample_assembler (
	input  logic                                               clk_in,
	input  logic                                               rst_in,
	input  ltc2195_pkg::lane_word_t [ltc2195_pkg::N_LANES-1:0] words,
	input  logic                                               word_valid,
	output ltc2195_pkg::sample_t                               adc0,
	output ltc2195_pkg::sample_t                               adc1,
	output ltc2195_pkg::lane_word_t                            frame,
	output logic                                               sample_valid
);
	import ltc2195_pkg::*;

	// Two lanes per sample, odd bits from the first lane, even bits from the second
	function automatic sample_t interleave(input lane_word_t lane_hi, input lane_word_t lane_lo);
		sample_t s;
		for (int k = 0; k < LANE_BITS; k++) begin
			s[15 - 2*k] = lane_hi[7 - k];
			s[14 - 2*k] = lane_lo[7 - k];
		end
		return s;
	endfunction

	// Sample payload
	always_ff @(posedge clk_in) begin
		if (word_valid) begin
			adc0  <= interleave(words[0], words[1]); // Lanes 0 and 1
			adc1  <= interleave(words[2], words[3]); // Lanes 2 and 3, same rule
			frame <= words[4];
		end
	end

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in)
			sample_valid <= 1'b0;
		else
			sample_valid <= word_valid; // One edge behind the lane words
	end

endmodule

/* rtl/frame_aligner.sv */
// Bitslip FSM locking the word boundary to the frame lane training pattern
module frame_aligner (
	input  logic                    clk_in,
	input  logic                    rst_in,
	input  ltc2195_pkg::lane_word_t frame_word,
	input  logic                    word_valid,
	output logic                    slip,
	output logic                    frame_locked
);
	import ltc2195_pkg::*;

	align_state_e state;
	logic [1:0]   mis_cnt; // Consecutive mismatching frame words

	localparam logic [1:0] MIS_LAST = 2'(SLIP_WAIT - 1);

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state        <= CHECK;
			mis_cnt      <= 2'd0;
			frame_locked <= 1'b0;
		end else begin
			case (state)
				CHECK: begin
					if (word_valid) begin
						if (frame_word == TRAINING_PATTERN) begin
							frame_locked <= 1'b1;
							mis_cnt      <= 2'd0;
						end else begin
							frame_locked <= 1'b0;
							// Words already in flight still show the old boundary
							if (mis_cnt == MIS_LAST)
								state <= SLIP;
							else
								mis_cnt <= mis_cnt + 2'd1;
						end
					end
				end
				SLIP: begin
					mis_cnt <= 2'd0; // Restart the count after the slip
					state   <= CHECK;
				end
				default: state <= CHECK;
			endcase
		end
	end

	assign slip = (state == SLIP); // One cycle per visit

endmodule

/* rtl/lane_deserializer.sv */
// Serial-to-parallel conversion of all lanes with a shared bit counter and bitslip
module lane_deserializer (
	input  logic                                               clk_in,
	input  logic                                               rst_in,
	input  logic [ltc2195_pkg::N_LANES-1:0]                    lane_d,
	input  logic                                               slip,
	output ltc2195_pkg::lane_word_t [ltc2195_pkg::N_LANES-1:0] words,
	output logic                                               word_valid
);
	import ltc2195_pkg::*;

	localparam int CNT_W = $clog2(LANE_BITS);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(LANE_BITS - 1);

	lane_word_t [N_LANES-1:0] shift_q; // One shift register per lane
	logic [CNT_W-1:0]         bit_cnt; // Bit position within the word
	logic                     word_done; // shift_q holds a full word

	// Shift in, first bit of a word ends up in bit 7
	always_ff @(posedge clk_in) begin
		for (int i = 0; i < N_LANES; i++) begin
			shift_q[i] <= {shift_q[i][LANE_BITS-2:0], lane_d[i]};
		end
		if (word_done)
			words <= shift_q; // Captured before the next bit lands
	end

	////////////////////////////////////////
	// Word boundary
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			bit_cnt    <= '0;
			word_done  <= 1'b0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= word_done;
			if (slip) begin
				// Hold the count one bit, so the word takes 9 bits
				word_done <= 1'b0;
			end else begin
				bit_cnt   <= bit_cnt + 1'b1; // Wraps after the 8th bit
				word_done <= (bit_cnt == BIT_LAST);
			end
		end
	end

endmodule

/* rtl/adc_config_seq.sv */
// ADC configuration sequencer: power-on wait, three init writes, host SPI write commands
module adc_config_seq (
	input  logic                   clk_in,
	input  logic                   rst_in,
	input  logic                   cmd_trig,
	input  logic [15:0]            cmd_addr,
	input  logic [15:0]            cmd_data,
	input  logic                   spi_ready,
	output ltc2195_pkg::spi_word_t spi_word,
	output logic                   spi_start,
	output logic                   cfg_ready
);
	import ltc2195_pkg::*;

	cfg_state_e state;
	logic [7:0] por_cnt;  // Power-on count-down
	logic [1:0] init_idx; // Next init word, 3 once all are sent

	// Init word table
	function automatic spi_word_t init_word(input logic [1:0] idx);
		spi_word_t w;
		case (idx)
			2'd0:    w = INIT_WORD_RESET;
			2'd1:    w = INIT_WORD_FORMAT;
			default: w = INIT_WORD_LANES;
		endcase
		return w;
	endfunction

	////////////////////////////////////////
	// Sequencer FSM
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state    <= CFG_POR_WAIT;
			por_cnt  <= POR_WAIT_CYCLES;
			init_idx <= 2'd0;
		end else begin
			case (state)
				CFG_POR_WAIT: begin
					if (por_cnt == 8'd0)
						state <= CFG_INIT_LOAD;
					else
						por_cnt <= por_cnt - 8'd1;
				end
				CFG_INIT_LOAD: begin
					state <= CFG_START; // Word settles one cycle before start
				end
				CFG_START: begin
					state <= CFG_WAIT;  // spi_ready goes low on this edge
				end
				CFG_WAIT: begin
					if (spi_ready) begin
						if (init_idx != 2'd3)
							init_idx <= init_idx + 2'd1; // Host writes leave it at 3
						// Last init word or host write returns to idle
						state <= (init_idx >= 2'd2) ? CFG_IDLE : CFG_INIT_LOAD;
					end
				end
				CFG_IDLE: begin
					// Only page 31h starts a frame, other pages fall through
					if (cmd_trig && (cmd_addr[15:8] == CMD_PAGE_SPI_WRITE))
						state <= CFG_START;
				end
				default: state <= CFG_IDLE;
			endcase
		end
	end

	// Frame to send, held until the SPI master loads it
	always_ff @(posedge clk_in) begin
		if (state == CFG_INIT_LOAD)
			spi_word <= init_word(init_idx);
		else if (state == CFG_IDLE && cmd_trig)
			spi_word <= {1'b0, cmd_addr[6:0], cmd_data[7:0]}; // Write bit, addr, data
	end

	assign spi_start = (state == CFG_START); // Exactly one cycle per frame
	assign cfg_ready = (state == CFG_IDLE);  // Falls the edge after an accepted command

endmodule

/* rtl/spi_master.sv */
// Write-only 16-bit SPI master with SCK divider, MSB first, mode 0 timing
module spi_master #(
	parameter int SPI_CLK_DIV = 4 // clk_in cycles per SCK half-period
) (
	input  logic                   clk_in,
	input  logic                   rst_in,
	input  ltc2195_pkg::spi_word_t spi_word,
	input  logic                   spi_start,
	output logic                   spi_ready,
	output logic                   spi_scs,
	output logic                   spi_sck,
	output logic                   spi_sdo
);
	import ltc2195_pkg::*;

	// Counter widths, divider kept at least one bit wide for SPI_CLK_DIV of 1
	localparam int DIV_W  = $clog2(SPI_CLK_DIV + 1);
	localparam int HALF_W = $clog2(2 * SPI_WORD_BITS);

	localparam logic [DIV_W-1:0]  DIV_LAST  = DIV_W'(SPI_CLK_DIV - 1);
	localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(2 * SPI_WORD_BITS - 1);

	logic              busy;     // Frame in progress
	logic [DIV_W-1:0]  div_cnt;  // clk_in count within a half-period
	logic [HALF_W-1:0] half_cnt; // SCK half-period index, 0..31
	spi_word_t         shift_q;  // Outgoing bits, MSB on the pin

	////////////////////////////////////////
	// Frame engine
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			busy     <= 1'b0;
			spi_sck  <= 1'b0;
			div_cnt  <= '0;
			half_cnt <= '0;
			shift_q  <= '0;
		end else if (!busy) begin
			if (spi_start) begin
				busy     <= 1'b1;    // scs drops on this edge
				shift_q  <= spi_word; // First bit on SDO right away
				div_cnt  <= '0;
				half_cnt <= '0;
			end
		end else if (div_cnt == DIV_LAST) begin
			// End of a half-period
			div_cnt  <= '0;
			spi_sck  <= ~spi_sck;
			half_cnt <= half_cnt + 1'b1; // Wraps to 0 after the last one
			if (spi_sck) begin
				// Falling SCK, next bit out
				shift_q <= {shift_q[SPI_WORD_BITS-2:0], 1'b0};
			end
			if (half_cnt == HALF_LAST) begin
				busy <= 1'b0; // 16th period done, release scs
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Pins and handshake, all straight from flops
	assign spi_scs   = ~busy;                     // Active low
	assign spi_ready = ~busy;                     // Low for the whole frame
	assign spi_sdo   = shift_q[SPI_WORD_BITS-1];  // Stable across rising SCK

endmodule

/* rtl/ltc2195_pkg.sv */
// Shared widths, types, state and command enums, init words and frame training pattern
package ltc2195_pkg;

	////////////////////////////////////////
	// Widths
	parameter int LANE_BITS     = 8;  // Bits per deserialized lane word
	parameter int N_LANES       = 5;  // Lanes 0-1 ADC0, 2-3 ADC1, 4 frame
	parameter int SPI_WORD_BITS = 16; // SPI frame length

	typedef logic [LANE_BITS-1:0]     lane_word_t;
	typedef logic [SPI_WORD_BITS-1:0] spi_word_t;  // {write bit, addr[6:0], data[7:0]}
	typedef logic signed [15:0]       sample_t;    // Two's-complement ADC sample

	////////////////////////////////////////
	// Host command pages, upper byte of cmd_addr
	typedef enum logic [7:0] {
		CMD_PAGE_SPI_WRITE = 8'h31 // Write one 8-bit SPI register
	} cmd_page_e;

	// Power-on register writes, sent in this order
	parameter spi_word_t INIT_WORD_RESET  = 16'h0080; // Reg 0, software reset
	parameter spi_word_t INIT_WORD_FORMAT = 16'h0120; // Reg 1, two's-complement output
	parameter spi_word_t INIT_WORD_LANES  = 16'h0200; // Reg 2, two-lane mode

	parameter logic [7:0] POR_WAIT_CYCLES = 8'd255; // Count-down before first SPI write

	////////////////////////////////////////
	// Frame alignment
	parameter lane_word_t TRAINING_PATTERN = 8'b10000111; // Expected frame lane word
	parameter int         SLIP_WAIT        = 3;           // Mismatches before a bitslip

	// Configuration sequencer states
	typedef enum logic [2:0] {
		CFG_POR_WAIT,  // Power-on count-down
		CFG_INIT_LOAD, // Load next init word
		CFG_START,     // One-cycle start to SPI master
		CFG_WAIT,      // Wait for the frame to end
		CFG_IDLE       // Ready for host commands
	} cfg_state_e;

	// Bitslip machine states
	typedef enum logic {
		CHECK,
		SLIP
	} align_state_e;

endpackage
